/* logic/ciPackage.sv */
package ciPackage;

  // Decoded custom instruction, numbered after its CPU-side id
  typedef enum logic [7:0] {
    ciNone      = 8'd0,
    ciSwapBytes = 8'd1,
    ciProfile   = 8'd8,
    ciGrayscale = 8'd12
  } ciOpcode;

  typedef logic [31:0] ciWord;

  // 0 cycles, 1 stall, 2 bus idle, 3 reads as zero
  typedef logic [1:0] profileCounterIndex;

  // Grayscale weights, they add up to 256
  localparam logic [7:0] redWeight   = 8'd54;
  localparam logic [7:0] greenWeight = 8'd183;
  localparam logic [7:0] blueWeight  = 8'd19;

endpackage

/* logic/resetSequencer.sv */
`timescale 1ns/1ns

module resetSequencer #(
  parameter int resetCountBits = 5
) (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic coprocessorReset
);

  logic [resetCountBits-1:0] resetCount;

  // Counts up once the clock source is locked, stops on the top bit
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[resetCountBits-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign coprocessorReset = ~resetCount[resetCountBits-1];

endmodule

/* logic/ciDispatch.sv */
`timescale 1ns/1ns

module ciDispatch import ciPackage::*; (
  input  logic    s_systemClock,
  input  logic    coprocessorReset,
  input  logic    ciStart,
  input  logic    [7:0] ciN,
  input  ciWord   ciDataA,
  input  ciWord   ciDataB,
  output logic    stageValid,
  output ciOpcode stageOpcode,
  output ciWord   stageDataA,
  output ciWord   stageDataB
);

  ciOpcode decodedOpcode;

  always_comb begin
    case (ciN)
      8'd1:    decodedOpcode = ciSwapBytes;
      8'd8:    decodedOpcode = ciProfile;
      8'd12:   decodedOpcode = ciGrayscale;
      default: decodedOpcode = ciNone; // Not ours, dropped here
    endcase
  end

  always_ff @(posedge s_systemClock or posedge coprocessorReset) begin
    if (coprocessorReset) begin
      stageValid  <= 1'b0;
      stageOpcode <= ciNone;
    end else begin
      stageValid  <= ciStart && (decodedOpcode != ciNone);
      stageOpcode <= decodedOpcode;
    end
  end

  always_ff @(posedge s_systemClock) begin
    stageDataA <= ciDataA;
    stageDataB <= ciDataB;
  end

endmodule

/* logic/profileCounters.sv */
`timescale 1ns/1ns

module profileCounters import ciPackage::*; #(
  parameter int counterWidth = 32
) (
  input  logic               s_systemClock,
  input  logic               coprocessorReset,
  input  logic               stall,
  input  logic               busIdle,
  input  logic               controlStrobe,
  input  ciWord              controlWord,
  input  profileCounterIndex readIndex,
  output ciWord              readValue
);

  logic [counterWidth-1:0] counterValue [3];
  logic [2:0]              counterEnabled;
  logic [2:0]              countEvent;
  logic [2:0]              enableMask;
  logic [2:0]              disableMask;
  logic [2:0]              clearMask;

  assign countEvent = {busIdle, stall, 1'b1}; // Counter 0 sees every cycle

  // Control fields are only honoured on a profiling instruction
  assign enableMask  = controlStrobe ? controlWord[2:0]  : 3'b000;
  assign disableMask = controlStrobe ? controlWord[6:4]  : 3'b000;
  assign clearMask   = controlStrobe ? controlWord[10:8] : 3'b000;

  always_ff @(posedge s_systemClock or posedge coprocessorReset) begin
    if (coprocessorReset) begin
      counterEnabled <= 3'b000;
    end else begin
      counterEnabled <= (counterEnabled | enableMask) & ~disableMask; // Disable wins
    end
  end

  always_ff @(posedge s_systemClock or posedge coprocessorReset) begin
    if (coprocessorReset) begin
      for (int i = 0; i < 3; i++) begin
        counterValue[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (clearMask[i]) begin
          counterValue[i] <= '0;
        end else if (counterEnabled[i] && countEvent[i]) begin
          counterValue[i] <= counterValue[i] + 1'b1;
        end
      end
    end
  end

  // Zero-extended to a full word
  always_comb begin
    readValue = '0;
    case (readIndex)
      2'd0:    readValue[counterWidth-1:0] = counterValue[0];
      2'd1:    readValue[counterWidth-1:0] = counterValue[1];
      2'd2:    readValue[counterWidth-1:0] = counterValue[2];
      default: readValue = '0;
    endcase
  end

endmodule

/* logic/ciExecute.sv */
`timescale 1ns/1ns

module ciExecute import ciPackage::*; #(
  parameter int counterWidth = 32
) (
  input  logic        s_systemClock,
  input  logic        coprocessorReset,
  input  logic        stall,
  input  logic        busIdle,
  input  logic        stageValid,
  input  ciOpcode     stageOpcode,
  input  ciWord       stageDataA,
  input  ciWord       stageDataB,
  output logic        resultValid,
  output ciOpcode     resultOpcode,
  output ciWord       swapWord,
  output ciWord       profileWord,
  output logic [15:0] redProduct,
  output logic [15:0] greenProduct,
  output logic [15:0] blueProduct
);

  logic  profileStrobe;
  ciWord counterRead;
  logic  [7:0] red8;
  logic  [7:0] green8;
  logic  [7:0] blue8;

  assign profileStrobe = stageValid && (stageOpcode == ciProfile);

  profileCounters #(
    .counterWidth(counterWidth)
  ) counters (
    .s_systemClock(s_systemClock),
    .coprocessorReset(coprocessorReset),
    .stall(stall),
    .busIdle(busIdle),
    .controlStrobe(profileStrobe),
    .controlWord(stageDataB),
    .readIndex(stageDataA[1:0]),
    .readValue(counterRead)
  );

  // RGB565 channels widened to 8 bits
  assign red8   = {stageDataA[15:11], 3'b000};
  assign green8 = {stageDataA[10:5], 2'b00};
  assign blue8  = {stageDataA[4:0], 3'b000};

  always_ff @(posedge s_systemClock or posedge coprocessorReset) begin
    if (coprocessorReset) begin
      resultValid  <= 1'b0;
      resultOpcode <= ciNone;
    end else begin
      resultValid  <= stageValid;
      resultOpcode <= stageOpcode;
    end
  end

  always_ff @(posedge s_systemClock) begin
    swapWord     <= {stageDataA[7:0], stageDataA[15:8], stageDataA[23:16], stageDataA[31:24]};
    profileWord  <= counterRead; // Value before this edge's control
    redProduct   <= red8 * redWeight;
    greenProduct <= green8 * greenWeight;
    blueProduct  <= blue8 * blueWeight;
  end

endmodule

/* logic/ciResultStage.sv */
`timescale 1ns/1ns

module ciResultStage import ciPackage::*; (
  input  logic        s_systemClock,
  input  logic        coprocessorReset,
  input  logic        resultValid,
  input  ciOpcode     resultOpcode,
  input  ciWord       swapWord,
  input  ciWord       profileWord,
  input  logic [15:0] redProduct,
  input  logic [15:0] greenProduct,
  input  logic [15:0] blueProduct,
  output logic        ciDone,
  output ciWord       ciResult
);

  logic  [15:0] graySum;
  ciWord grayWord;
  ciWord selectedWord;

  // Weights add up to 256, so 16 bits cannot overflow
  assign graySum  = redProduct + greenProduct + blueProduct;
  assign grayWord = {24'd0, graySum[15:8]};

  always_comb begin
    case (resultOpcode)
      ciSwapBytes: selectedWord = swapWord;
      ciProfile:   selectedWord = profileWord;
      ciGrayscale: selectedWord = grayWord;
      default:     selectedWord = '0;
    endcase
  end

  // Result bus stays at zero between done pulses
  always_ff @(posedge s_systemClock or posedge coprocessorReset) begin
    if (coprocessorReset) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= resultValid;
      ciResult <= resultValid ? selectedWord : '0;
    end
  end

endmodule

/* logic/ciCoprocessor.sv */
`timescale 1ns/1ns

module ciCoprocessor import ciPackage::*; #(
  parameter int resetCountBits = 5,
  parameter int counterWidth   = 32
) (
  input  logic  s_systemClock,
  input  logic  s_pllLocked,
  input  logic  ciStart,
  input  logic  [7:0] ciN,
  input  ciWord ciDataA,
  input  ciWord ciDataB,
  input  logic  stall,
  input  logic  busIdle,
  output logic  resetDone,
  output logic  ciDone,
  output ciWord ciResult
);

  logic        coprocessorReset;
  logic        stageValid;
  ciOpcode     stageOpcode;
  ciWord       stageDataA;
  ciWord       stageDataB;
  logic        resultValid;
  ciOpcode     resultOpcode;
  ciWord       swapWord;
  ciWord       profileWord;
  logic [15:0] redProduct;
  logic [15:0] greenProduct;
  logic [15:0] blueProduct;

  assign resetDone = ~coprocessorReset;

  resetSequencer #(.resetCountBits(resetCountBits)) resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .coprocessorReset(coprocessorReset)
  );

  ciDispatch dispatch (
    .s_systemClock(s_systemClock),
    .coprocessorReset(coprocessorReset),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .stageValid(stageValid),
    .stageOpcode(stageOpcode),
    .stageDataA(stageDataA),
    .stageDataB(stageDataB)
  );

  ciExecute #(.counterWidth(counterWidth)) execute (
    .s_systemClock(s_systemClock),
    .coprocessorReset(coprocessorReset),
    .stall(stall),
    .busIdle(busIdle),
    .stageValid(stageValid),
    .stageOpcode(stageOpcode),
    .stageDataA(stageDataA),
    .stageDataB(stageDataB),
    .resultValid(resultValid),
    .resultOpcode(resultOpcode),
    .swapWord(swapWord),
    .profileWord(profileWord),
    .redProduct(redProduct),
    .greenProduct(greenProduct),
    .blueProduct(blueProduct)
  );

  ciResultStage result (
    .s_systemClock(s_systemClock),
    .coprocessorReset(coprocessorReset),
    .resultValid(resultValid),
    .resultOpcode(resultOpcode),
    .swapWord(swapWord),
    .profileWord(profileWord),
    .redProduct(redProduct),
    .greenProduct(greenProduct),
    .blueProduct(blueProduct),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

endmodule

/* include/ciReference.svh */
`ifndef CI_REFERENCE_SVH
`define CI_REFERENCE_SVH

function automatic logic [31:0] referenceSwap(input logic [31:0] value);
  return {value[7:0], value[15:8], value[23:16], value[31:24]};
endfunction

// RGB565 channels shifted up to 8 bits and weighted 54, 183 and 19
function automatic logic [31:0] referenceGray(input logic [15:0] pixel);
  int unsigned sum;
  sum = {pixel[15:11], 3'b000} * 54
      + {pixel[10:5], 2'b00} * 183
      + {pixel[4:0], 3'b000} * 19;
  return {24'd0, sum[15:8]};
endfunction

// Growth of one profiling counter whose event input holds a single level
function automatic logic [31:0] counterGrowth(input bit enabled, input bit eventLevel,
                                              input int cycles);
  return (enabled && eventLevel) ? 32'(cycles) : 32'd0;
endfunction

`endif

/* tb/ciCoprocessorTb.sv */
`timescale 1ns/1ns

`include "ciReference.svh"

module ciCoprocessorTb;

  localparam int issuedInstructions = 31;
  localparam int watchdogCycles     = issuedInstructions * 10 + 200;

  logic        s_systemClock = 1'b0;
  logic        s_pllLocked;
  logic        ciStart;
  logic [7:0]  ciN;
  logic [31:0] ciDataA;
  logic [31:0] ciDataB;
  logic        stall;
  logic        busIdle;
  logic        resetDone;
  logic        ciDone;
  logic [31:0] ciResult;

  int          edgeCount = 0;
  int          lastIssueEdge;
  int          mismatchCount = 0;
  int          failureCount = 0;
  logic [31:0] lfsrState = 32'h32a7b11a;
  logic [31:0] lastProfileRead;

  // Scoreboard with one entry per instruction that should complete
  int          expectedEdge [$];
  logic [31:0] expectedResult [$];
  bit          checkValue [$];

  ciCoprocessor #(
    .resetCountBits(5),
    .counterWidth(32)
  ) UUT (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .stall(stall),
    .busIdle(busIdle),
    .resetDone(resetDone),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

  always #50 s_systemClock = ~s_systemClock;

  always @(posedge s_systemClock) begin
    edgeCount <= edgeCount + 1;
  end

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] nextRandom(input int bitCount);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < bitCount; i++) begin
      feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], feedback};
      value     = {value[30:0], feedback};
    end
    return value;
  endfunction

  task automatic reportMismatch(input string signalName, input logic [31:0] actual,
                                input logic [31:0] expected);
    $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, signalName, actual, expected);
    mismatchCount++;
  endtask

  task automatic reportFailure(input string what);
    $display("FAILURE at %0t ns: %s", $time, what);
    failureCount++;
  endtask

  // Start goes out on the next rising edge and is sampled one edge later
  task automatic issueInstruction(input logic [7:0] id, input logic [31:0] a,
                                  input logic [31:0] b, input bit expectDone,
                                  input bit checkResult, input logic [31:0] expected);
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= id;
    ciDataA <= a;
    ciDataB <= b;
    lastIssueEdge = edgeCount;
    if (expectDone) begin
      expectedEdge.push_back(edgeCount + 4); // Three register stages after the sampling edge
      expectedResult.push_back(expected);
      checkValue.push_back(checkResult);
    end
  endtask

  task automatic idleCycles(input int count);
    repeat (count) begin
      @(posedge s_systemClock);
      ciStart <= 1'b0;
    end
  endtask

  task automatic waitForResults();
    while (expectedEdge.size() != 0) begin
      @(posedge s_systemClock);
    end
  endtask

  task automatic readCounter(input logic [1:0] index, input logic [31:0] control,
                             output logic [31:0] value, output int issueEdge);
    issueInstruction(8'd8, {30'd0, index}, control, 1'b1, 1'b0, '0);
    issueEdge = lastIssueEdge;
    idleCycles(1);
    waitForResults();
    value = lastProfileRead;
  endtask

  // Checks every completion on the falling edge where outputs are settled
  always @(negedge s_systemClock) begin
    if (edgeCount > 0) begin
      if (ciDone) begin
        assert (expectedEdge.size() != 0) else
          reportFailure("ciDone pulsed with nothing in flight");
        if (expectedEdge.size() != 0) begin
          assert (expectedEdge[0] == edgeCount) else
            reportMismatch("ciDone edge", 32'(edgeCount), 32'(expectedEdge[0]));
          if (checkValue[0]) begin
            assert (ciResult == expectedResult[0]) else
              reportMismatch("ciResult", ciResult, expectedResult[0]);
          end else begin
            lastProfileRead = ciResult;
          end
          void'(expectedEdge.pop_front());
          void'(expectedResult.pop_front());
          void'(checkValue.pop_front());
        end
      end else begin
        assert (ciResult == '0) else reportMismatch("ciResult", ciResult, 32'd0);
        assert (expectedEdge.size() == 0 || expectedEdge[0] > edgeCount) else
          reportFailure("ciDone missing for an issued instruction");
        if (expectedEdge.size() != 0 && expectedEdge[0] <= edgeCount) begin
          void'(expectedEdge.pop_front());
          void'(expectedResult.pop_front());
          void'(checkValue.pop_front());
        end
      end
    end
  end

  initial begin
    repeat (watchdogCycles) @(posedge s_systemClock);
    $display("Timeout: run still busy after %0d cycles", watchdogCycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic [31:0] operand;
    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] expectedDelta;
    int          firstEdge;
    int          secondEdge;
    s_pllLocked = 1'b0;
    ciStart     = 1'b0;
    ciN         = 8'd0;
    ciDataA     = '0;
    ciDataB     = '0;
    stall       = 1'b0;
    busIdle     = 1'b1;

    repeat (3) @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    // A start inside the reset window must be ignored
    for (int i = 1; i <= 16; i++) begin
      @(posedge s_systemClock);
      ciStart <= (i == 4);
      ciN     <= 8'd1;
      @(negedge s_systemClock);
      assert (resetDone == (i == 16)) else
        reportMismatch("resetDone", 32'(resetDone), 32'(i == 16));
    end

    operand = nextRandom(32);
    issueInstruction(8'd1, operand, nextRandom(32), 1'b1, 1'b1, referenceSwap(operand));
    idleCycles(1);
    waitForResults();
    for (int i = 0; i < 6; i++) begin
      operand = nextRandom(32);
      issueInstruction(8'd1, operand, nextRandom(32), 1'b1, 1'b1, referenceSwap(operand));
    end
    idleCycles(1);
    waitForResults();

    for (int i = 0; i < 8; i++) begin
      operand = {16'd0, nextRandom(16)};
      issueInstruction(8'd12, operand, '0, 1'b1, 1'b1, referenceGray(operand[15:0]));
    end
    issueInstruction(8'd12, 32'h0000ffff, '0, 1'b1, 1'b1, referenceGray(16'hffff));
    issueInstruction(8'd12, 32'h00000000, '0, 1'b1, 1'b1, referenceGray(16'h0000));
    idleCycles(1);
    waitForResults();

    // Clear and enable all three counters
    readCounter(2'd0, 32'h00000707, first, firstEdge);
    readCounter(2'd0, '0, first, firstEdge);
    idleCycles(5 + int'(nextRandom(3)));
    readCounter(2'd0, '0, second, secondEdge);
    expectedDelta = counterGrowth(1'b1, 1'b1, secondEdge - firstEdge);
    assert (second - first == expectedDelta) else
      reportMismatch("cycle counter delta", second - first, expectedDelta);
    readCounter(2'd1, '0, first, firstEdge);
    idleCycles(5 + int'(nextRandom(3)));
    readCounter(2'd1, '0, second, secondEdge);
    expectedDelta = counterGrowth(1'b1, stall, secondEdge - firstEdge);
    assert (second - first == expectedDelta) else
      reportMismatch("stall counter delta", second - first, expectedDelta);
    readCounter(2'd2, '0, first, firstEdge);
    idleCycles(5 + int'(nextRandom(3)));
    readCounter(2'd2, '0, second, secondEdge);
    expectedDelta = counterGrowth(1'b1, busIdle, secondEdge - firstEdge);
    assert (second - first == expectedDelta) else
      reportMismatch("bus idle counter delta", second - first, expectedDelta);
    readCounter(2'd0, 32'h00000010, first, firstEdge); // Stop counter 0
    readCounter(2'd0, '0, first, firstEdge);
    idleCycles(7);
    readCounter(2'd0, '0, second, secondEdge);
    expectedDelta = counterGrowth(1'b0, 1'b1, secondEdge - firstEdge);
    assert (second - first == expectedDelta) else
      reportMismatch("disabled cycle counter delta", second - first, expectedDelta);
    readCounter(2'd3, '0, first, firstEdge);
    assert (first == '0) else reportMismatch("counter index 3", first, 32'd0);

    // Ids that belong to nobody
    issueInstruction(8'd7, nextRandom(32), nextRandom(32), 1'b0, 1'b0, '0);
    idleCycles(1);
    issueInstruction(8'd200, nextRandom(32), nextRandom(32), 1'b0, 1'b0, '0);
    idleCycles(6);
    waitForResults();

    $display("Error counts: %0d mismatches, %0d other failures", mismatchCount, failureCount);
    if (mismatchCount + failureCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
logic/ciPackage.sv
logic/resetSequencer.sv
logic/ciDispatch.sv
logic/profileCounters.sv
logic/ciExecute.sv
logic/ciResultStage.sv
logic/ciCoprocessor.sv
tb/ciCoprocessorTb.sv

/* run.sh */
#!/bin/sh
# Build and run from the project root, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module ciCoprocessorTb \
  -o ciCoprocessorSim > build.log 2>&1 &&
  ./obj_dir/ciCoprocessorSim > sim.log 2>&1 ||
  { cat build.log; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "Simulation passed" ||
  { echo "Simulation ended without a verdict"; exit 1; }
